// File: divsqrt_defines.svh
// Global sizing for the integer divide / square-root unit
// Include wherever widths or pipeline depths are needed

`ifndef DIVSQRT_DEFINES_SVH
`define DIVSQRT_DEFINES_SVH

// Datapath width of operands, quotient, root and remainder
`define DIVSQRT_WIDTH 32

// Sideband tag carried alongside each request
`define DIVSQRT_TAG_WIDTH 4

// Elastic register stages in front of the controller
`define DIVSQRT_NUM_INP_REGS 1

// Elastic register stages behind the controller
`define DIVSQRT_NUM_OUT_REGS 1

`endif

// File: divsqrt_types_pkg.sv
// Request, response and opcode types of the divide / square-root unit
// Shared by the datapath blocks and the testbench

`default_nettype none

`include "divsqrt_defines.svh"

package divsqrt_types_pkg;

  // Operation select, one bit
  typedef enum logic {
    DIV  = 1'b0,  // Quotient and remainder of a / b
    SQRT = 1'b1   // Floor root of a, remainder a - root^2
  } divsqrt_op_e;

  // Request as it travels through the input stages
  typedef struct packed {
    divsqrt_op_e                   op;
    logic [`DIVSQRT_WIDTH-1:0]     operand_a;  // Dividend or radicand
    logic [`DIVSQRT_WIDTH-1:0]     operand_b;  // Divisor, don't care for SQRT
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;
  } divsqrt_req_t;

  typedef struct packed {
    logic div_by_zero;  // Divisor was zero, result is all ones
  } divsqrt_status_t;

  // Response as it travels through the output stages
  typedef struct packed {
    logic [`DIVSQRT_WIDTH-1:0]     result;     // Quotient or root
    logic [`DIVSQRT_WIDTH-1:0]     remainder;
    divsqrt_status_t               status;
    logic [`DIVSQRT_TAG_WIDTH-1:0] tag;        // Copied from the request
  } divsqrt_rsp_t;

endpackage

`default_nettype wire

// File: divsqrt_ctrl_pkg.sv
// State encoding of the issue / hold controller
// Imported by the controller, and by the testbench for messages

`default_nettype none

package divsqrt_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Waiting for a request
    BUSY = 2'd1,  // Engine running
    HOLD = 2'd2   // Result waiting for downstream
  } divsqrt_state_e;

endpackage

`default_nettype wire

// File: divsqrt_pipe_stage.sv
// One elastic pipeline register with valid/ready handshake and flush
// Chained in the top level for both the request and response paths

`default_nettype none

module divsqrt_pipe_stage #(
  parameter type data_t = logic  // Payload carried by the stage
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  flush_i,   // Synchronous clear of the valid bit
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  logic  valid_q;
  data_t data_q;

  // Advance when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // Drop whatever is in flight
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only loads on an actual transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;  // Stable while valid_o waits for ready_i

endmodule

`default_nettype wire

// File: divsqrt_iter_unit.sv
// Radix-2 restoring engine for unsigned divide and square root
// Pulse start_i with op and operands, results are valid from the done_o pulse on

`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_iter_unit import divsqrt_types_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,        // Aborts a running operation
  input  logic                      start_i,        // One-cycle start pulse
  input  divsqrt_op_e               op_i,
  input  logic [`DIVSQRT_WIDTH-1:0] operand_a_i,    // Dividend or radicand
  input  logic [`DIVSQRT_WIDTH-1:0] operand_b_i,    // Divisor
  output logic                      done_o,         // One-cycle completion pulse
  output logic [`DIVSQRT_WIDTH-1:0] result_o,       // Quotient or root
  output logic [`DIVSQRT_WIDTH-1:0] remainder_o,
  output logic                      div_by_zero_o
);

  localparam int unsigned W     = `DIVSQRT_WIDTH;
  localparam int unsigned CNT_W = $clog2(W + 1);

  // Control state
  logic [CNT_W-1:0] cnt_q;   // Iterations left, zero when idle
  logic             done_q;

  // Operation registers
  divsqrt_op_e      op_q;
  logic [W-1:0]     opa_q;   // Dividend / radicand, consumed MSB first
  logic [W-1:0]     opb_q;   // Divisor
  logic [W-1:0]     rem_q;   // Partial remainder
  logic [W-1:0]     res_q;   // Quotient or root, built LSB in
  logic             dbz_q;

  // Trial subtraction, two guard bits cover the SQRT shift
  logic [W+1:0]     trial_rem;
  logic [W+1:0]     trial_sub;
  logic [W+1:0]     trial_diff;
  logic             trial_ok;

  // --------------------------------------------------------------------
  // Iteration datapath
  // --------------------------------------------------------------------
  always_comb begin
    if (op_q == SQRT) begin
      // Bring down two radicand bits, subtract 4*root + 1
      trial_rem = {rem_q, opa_q[W-1 -: 2]};
      trial_sub = {res_q, 2'b01};
    end else begin
      // Bring down one dividend bit, subtract the divisor
      trial_rem = {1'b0, rem_q, opa_q[W-1]};
      trial_sub = {2'b00, opb_q};
    end
    trial_ok   = (trial_rem >= trial_sub);  // No borrow, keep the difference
    trial_diff = trial_rem - trial_sub;
  end

  // --------------------------------------------------------------------
  // Iteration counter and done pulse
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (flush_i) begin
      cnt_q  <= '0;    // Abort, results are garbage until next start
      done_q <= 1'b0;
    end else begin
      done_q <= (cnt_q == CNT_W'(1));  // Last step retires this edge
      if (start_i) begin
        // One result bit per step: W for DIV, W/2 for SQRT
        cnt_q <= (op_i == SQRT) ? CNT_W'(W / 2) : CNT_W'(W);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Operands load on start, then shift once per step
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q  <= op_i;
      opa_q <= operand_a_i;
      opb_q <= operand_b_i;
      rem_q <= '0;
      res_q <= '0;
      dbz_q <= (op_i == DIV) && (operand_b_i == '0);
    end else if (cnt_q != '0) begin
      // Restore by keeping the unsubtracted value on a failed trial
      rem_q <= trial_ok ? trial_diff[W-1:0] : trial_rem[W-1:0];
      res_q <= {res_q[W-2:0], trial_ok};
      if (op_q == SQRT) begin
        opa_q <= {opa_q[W-3:0], 2'b00};
      end else begin
        opa_q <= {opa_q[W-2:0], 1'b0};
      end
    end
  end

  // Zero divisor passes every trial: quotient all ones, remainder the dividend
  assign done_o        = done_q;
  assign result_o      = res_q;
  assign remainder_o   = rem_q;
  assign div_by_zero_o = dbz_q;

endmodule

`default_nettype wire

// File: divsqrt_ctrl.sv
// Issue controller between the input stages, the engine and the output stages
// Starts one operation at a time and holds its result until downstream takes it

`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_ctrl import divsqrt_types_pkg::*; import divsqrt_ctrl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  // Request from the input stages
  input  divsqrt_req_t              req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  // Engine interface
  output logic                      start_o,
  input  logic                      unit_done_i,
  input  logic [`DIVSQRT_WIDTH-1:0] unit_result_i,
  input  logic [`DIVSQRT_WIDTH-1:0] unit_remainder_i,
  input  logic                      unit_div_by_zero_i,
  // Response to the output stages
  output divsqrt_rsp_t              rsp_o,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic                      busy_o     // Operation in flight
);

  divsqrt_state_e                state_q, state_d;
  logic [`DIVSQRT_TAG_WIDTH-1:0] tag_q;  // Tag of the running operation

  // --------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------
  always_comb begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) state_d = BUSY;
      end
      BUSY: begin
        busy_o = 1'b1;
        if (unit_done_i) begin
          rsp_valid_o = 1'b1;  // Result presented in the done cycle
          if (rsp_ready_i) begin
            state_d     = IDLE;
            req_ready_o = 1'b1;  // Back-to-back issue
            if (req_valid_i) state_d = BUSY;
          end else begin
            state_d = HOLD;  // Engine keeps its outputs stable meanwhile
          end
        end
      end
      HOLD: begin
        busy_o      = 1'b1;
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          state_d     = IDLE;
          req_ready_o = 1'b1;
          if (req_valid_i) state_d = BUSY;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      busy_o      = 1'b0;
      rsp_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  assign start_o = req_valid_i & req_ready_o & ~flush_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= IDLE;
    else           state_q <= state_d;
  end

  // Tag captured with the operands
  always_ff @(posedge clk_i) begin
    if (start_o) tag_q <= req_i.tag;
  end

  // Response assembly
  assign rsp_o.result             = unit_result_i;
  assign rsp_o.remainder          = unit_remainder_i;
  assign rsp_o.status.div_by_zero = unit_div_by_zero_i;
  assign rsp_o.tag                = tag_q;

endmodule

`default_nettype wire

// File: divsqrt_top.sv
// Top of the iterative unsigned divide / square-root unit
// Input stages feed the controller and engine while output stages carry the results off

`default_nettype none

`include "divsqrt_defines.svh"

module divsqrt_top import divsqrt_types_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         flush_i,
  // Request handshake
  input  divsqrt_req_t req_i,
  input  logic         in_valid_i,
  output logic         in_ready_o,
  // Response handshake
  output divsqrt_rsp_t rsp_o,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output logic         busy_o       // Any valid item in flight
);

  localparam int unsigned NUM_INP = `DIVSQRT_NUM_INP_REGS;
  localparam int unsigned NUM_OUT = `DIVSQRT_NUM_OUT_REGS;

  // Index i is the signal after i register stages
  divsqrt_req_t [0:NUM_INP] inp_data;
  logic         [0:NUM_INP] inp_valid;
  logic         [0:NUM_INP] inp_ready;
  divsqrt_rsp_t [0:NUM_OUT] out_data;
  logic         [0:NUM_OUT] out_valid;
  logic         [0:NUM_OUT] out_ready;

  // Controller to engine
  logic                      unit_start;
  logic                      unit_done;
  logic [`DIVSQRT_WIDTH-1:0] unit_result;
  logic [`DIVSQRT_WIDTH-1:0] unit_remainder;
  logic                      unit_div_by_zero;
  logic                      ctrl_busy;

  // --------------------------------------------------------------------
  // Input pipeline
  // --------------------------------------------------------------------
  assign inp_data[0]  = req_i;
  assign inp_valid[0] = in_valid_i;
  assign in_ready_o   = inp_ready[0];

  for (genvar i = 0; i < NUM_INP; i++) begin : gen_inp_pipe
    divsqrt_pipe_stage #(.data_t(divsqrt_req_t)) i_stage (
      .clk_i, .arst_n_i, .flush_i,
      .valid_i (inp_valid[i]),
      .ready_o (inp_ready[i]),
      .data_i  (inp_data[i]),
      .valid_o (inp_valid[i+1]),
      .ready_i (inp_ready[i+1]),
      .data_o  (inp_data[i+1])
    );
  end

  // --------------------------------------------------------------------
  // Controller and engine
  // --------------------------------------------------------------------
  divsqrt_ctrl i_ctrl (
    .clk_i, .arst_n_i, .flush_i,
    .req_i              (inp_data[NUM_INP]),
    .req_valid_i        (inp_valid[NUM_INP]),
    .req_ready_o        (inp_ready[NUM_INP]),
    .start_o            (unit_start),
    .unit_done_i        (unit_done),
    .unit_result_i      (unit_result),
    .unit_remainder_i   (unit_remainder),
    .unit_div_by_zero_i (unit_div_by_zero),
    .rsp_o              (out_data[0]),
    .rsp_valid_o        (out_valid[0]),
    .rsp_ready_i        (out_ready[0]),
    .busy_o             (ctrl_busy)
  );

  // Operands come straight from the last input stage and are sampled on start
  divsqrt_iter_unit i_unit (
    .clk_i, .arst_n_i, .flush_i,
    .start_i       (unit_start),
    .op_i          (inp_data[NUM_INP].op),
    .operand_a_i   (inp_data[NUM_INP].operand_a),
    .operand_b_i   (inp_data[NUM_INP].operand_b),
    .done_o        (unit_done),
    .result_o      (unit_result),
    .remainder_o   (unit_remainder),
    .div_by_zero_o (unit_div_by_zero)
  );

  // --------------------------------------------------------------------
  // Output pipeline
  // --------------------------------------------------------------------
  for (genvar i = 0; i < NUM_OUT; i++) begin : gen_out_pipe
    divsqrt_pipe_stage #(.data_t(divsqrt_rsp_t)) i_stage (
      .clk_i, .arst_n_i, .flush_i,
      .valid_i (out_valid[i]),
      .ready_o (out_ready[i]),
      .data_i  (out_data[i]),
      .valid_o (out_valid[i+1]),
      .ready_i (out_ready[i+1]),
      .data_o  (out_data[i+1])
    );
  end

  assign out_ready[NUM_OUT] = out_ready_i;  // Back-pressure enters here
  assign rsp_o              = out_data[NUM_OUT];
  assign out_valid_o        = out_valid[NUM_OUT];

  // Registered stage valids and the controller state
  assign busy_o = |{inp_valid[1:NUM_INP], ctrl_busy, out_valid[1:NUM_OUT]};

endmodule

`default_nettype wire

// File: tb_divsqrt.sv
// Directed testbench for the iterative divide / square-root unit
// Each test queues requests, streams them through the DUT and checks every response

`default_nettype none

`include "divsqrt_defines.svh"

module tb_divsqrt import divsqrt_types_pkg::*; import divsqrt_ctrl_pkg::*;;

  localparam int W              = `DIVSQRT_WIDTH;
  localparam int TIMEOUT_CYCLES = 40 * (`DIVSQRT_WIDTH + 10);

  logic         clk_i;
  logic         arst_n_i;
  logic         flush_i;
  divsqrt_req_t req_i;
  logic         in_valid_i;
  logic         in_ready_o;
  divsqrt_rsp_t rsp_o;
  logic         out_valid_o;
  logic         out_ready_i;
  logic         busy_o;

  divsqrt_req_t send_q[$];  // Requests not yet accepted
  divsqrt_rsp_t exp_q[$];   // Expected responses in issue order
  logic [`DIVSQRT_TAG_WIDTH-1:0] next_tag;
  int           errors;
  int           checks;
  int           cycles;
  integer       seed;
  divsqrt_state_e fsm_state;  // Controller state shown in error messages

  divsqrt_top dut0 (.*);

  assign fsm_state = dut0.i_ctrl.state_q;

  always #10 clk_i = ~clk_i;

  // Watchdog sized from the longest test sequence
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, responses still outstanding", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Testbench failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [W-1:0] floor_sqrt(input logic [W-1:0] a);
    logic [63:0] r;
    logic [63:0] t;
    r = '0;
    for (int i = W / 2 - 1; i >= 0; i--) begin
      t = r | (64'd1 << i);
      if (t * t <= {32'd0, a}) r = t;  // Largest root with root^2 <= a
    end
    return r[W-1:0];
  endfunction

  function automatic divsqrt_rsp_t expected_rsp(input divsqrt_req_t req);
    divsqrt_rsp_t rsp;
    logic [W-1:0] root;
    rsp     = '0;
    rsp.tag = req.tag;
    if (req.op == SQRT) begin
      root          = floor_sqrt(req.operand_a);
      rsp.result    = root;
      rsp.remainder = req.operand_a - root * root;
    end else if (req.operand_b == '0) begin
      rsp.result             = '1;             // All ones quotient
      rsp.remainder          = req.operand_a;  // Dividend comes back
      rsp.status.div_by_zero = 1'b1;
    end else begin
      rsp.result    = req.operand_a / req.operand_b;
      rsp.remainder = req.operand_a % req.operand_b;
    end
    return rsp;
  endfunction

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [W-1:0] act,
                               input logic [W-1:0] exp);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h", name, act, exp);
    end
  endtask

  task automatic enqueue_request(input divsqrt_op_e op, input logic [W-1:0] a,
                                 input logic [W-1:0] b);
    divsqrt_req_t req;
    req.op        = op;
    req.operand_a = a;
    req.operand_b = b;
    req.tag       = next_tag;
    next_tag++;  // Wraps at the tag width
    send_q.push_back(req);
  endtask

  task automatic check_response();
    divsqrt_rsp_t exp;
    checks++;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("Response with tag %h arrived while none was outstanding", rsp_o.tag);
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      compare_value("rsp_o.tag", W'(rsp_o.tag), W'(exp.tag));
      compare_value("rsp_o.result", rsp_o.result, exp.result);
      compare_value("rsp_o.remainder", rsp_o.remainder, exp.remainder);
      compare_value("rsp_o.status.div_by_zero", W'(rsp_o.status.div_by_zero),
                    W'(exp.status.div_by_zero));
    end
  endtask

  // Streams the send queue in and collects responses until both are empty
  task automatic drain_queue(input bit random_ready);
    while (send_q.size() != 0 || exp_q.size() != 0) begin
      @(posedge clk_i);
      #2;
      in_valid_i = (send_q.size() != 0);
      if (send_q.size() != 0) req_i = send_q[0];  // Held until accepted
      out_ready_i = random_ready ? ($random(seed) % 2 != 0) : 1'b1;
      @(negedge clk_i);  // Handshakes are settled for the next edge
      if (in_valid_i && in_ready_o) exp_q.push_back(expected_rsp(send_q.pop_front()));
      if (out_valid_o && out_ready_i) check_response();
    end
    @(posedge clk_i);
    #2;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic check_idle_after_reset();
    @(negedge clk_i);
    compare_value("out_valid_o", W'(out_valid_o), '0);
    compare_value("busy_o", W'(busy_o), '0);
    compare_value("in_ready_o", W'(in_ready_o), 1);
  endtask

  task automatic divide_directed();
    enqueue_request(DIV, 100, 7);
    enqueue_request(DIV, 5, 9);            // Dividend below divisor
    enqueue_request(DIV, '1, 1);
    enqueue_request(DIV, '1, '1);
    enqueue_request(DIV, '1, 3);
    enqueue_request(DIV, 0, 5);
    drain_queue(1'b0);
  endtask

  task automatic root_directed();
    enqueue_request(SQRT, 0, 0);
    enqueue_request(SQRT, 1, 0);
    enqueue_request(SQRT, 144, 0);
    enqueue_request(SQRT, 32'h0001_0000, 0);  // Perfect square of 256
    enqueue_request(SQRT, 1000, 0);
    enqueue_request(SQRT, '1, 0);
    drain_queue(1'b0);
  endtask

  task automatic divide_by_zero();
    enqueue_request(DIV, 1234, 0);
    enqueue_request(DIV, '1, 0);
    drain_queue(1'b0);
  endtask

  task automatic random_mixed_stream();
    divsqrt_op_e op;
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int i = 0; i < 20; i++) begin
      op = ($random(seed) % 2 != 0) ? SQRT : DIV;
      a  = $random(seed);
      b  = $random(seed) >> ($random(seed) & 31);  // Spread divisor magnitude
      enqueue_request(op, a, b);
    end
    drain_queue(1'b1);
  endtask

  task automatic flush_mid_operation();
    divsqrt_req_t req;
    req       = '{op: DIV, operand_a: 32'hdead_beef, operand_b: 32'h13, tag: next_tag};
    next_tag++;
    @(posedge clk_i);
    #2;
    req_i       = req;
    in_valid_i  = 1'b1;
    out_ready_i = 1'b1;
    @(negedge clk_i);
    compare_value("busy_o", W'(busy_o), '0);  // Offered only, nothing accepted yet
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("busy_o", W'(busy_o), 1);  // Engine is mid-iteration by now
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    compare_value("out_valid_o", W'(out_valid_o), '0);
    checks++;
    assert (!busy_o) else begin
      errors++;
      $display("Error: busy_o = %h after flush, FSM in %s", busy_o, fsm_state.name());
    end
    // Watch a full divide length for a leaked result
    repeat (W + 5) begin
      @(negedge clk_i);
      checks++;
      assert (!out_valid_o) else begin
        errors++;
        $display("A response with tag %h appeared after the flush", rsp_o.tag);
      end
    end
    enqueue_request(DIV, 1000, 33);
    drain_queue(1'b0);
  endtask

  initial begin
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    flush_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    next_tag    = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    seed        = 83;
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    check_idle_after_reset();
    divide_directed();
    root_directed();
    divide_by_zero();
    random_mixed_stream();
    flush_mid_operation();

    @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
divsqrt_types_pkg.sv
divsqrt_ctrl_pkg.sv
divsqrt_pipe_stage.sv
divsqrt_iter_unit.sv
divsqrt_ctrl.sv
divsqrt_top.sv
tb_divsqrt.sv

// File: Bender.yml
package:
  name: divsqrt

sources:
  - include_dirs:
      - .
    files:
      - divsqrt_types_pkg.sv
      - divsqrt_ctrl_pkg.sv
      - divsqrt_pipe_stage.sv
      - divsqrt_iter_unit.sv
      - divsqrt_ctrl.sv
      - divsqrt_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_divsqrt.sv
